/* hw/isaPkg.sv */
// --------------------------------------------------
// Vector ISA definitions
// Opcodes, instruction word layout and the decoded
// control bundle carried down the pipeline
// --------------------------------------------------

package isaPkg;

	// Register address into the 32-entry vector file
	typedef logic [4:0] regAddrT;

	// Opcode field in bits 7..3 of the instruction word
	typedef enum logic [4:0] {
		opNop   = 5'd0,
		opAdd   = 5'd1,
		opSub   = 5'd2,
		opMul   = 5'd3,
		opRelu  = 5'd4,
		opBcast = 5'd5
	} opcodeT;

	// Functional unit select in EX
	typedef enum logic [1:0] {
		fuAlu   = 2'd0,
		fuMul   = 2'd1,
		fuRelu  = 2'd2,
		fuBcast = 2'd3
	} fuSelT;

	// 32-bit instruction word with the MSB first
	typedef struct packed {
		logic [2:0] spareHi;
		regAddrT    dst;
		regAddrT    src1;
		regAddrT    src2;
		logic       sat;
		logic [4:0] spareMid;
		opcodeT     opcode;
		logic [2:0] spareLo;
	} instrT;

	// Decoded control for one instruction
	typedef struct packed {
		logic    regWrite;
		fuSelT   fuSel;
		logic    subtract;
		logic    sat;
		regAddrT dst;
	} ctrlT;

endpackage

/* hw/vecDatapathPkg.sv */
// --------------------------------------------------
// Vector datapath types
// Lane and vector widths, the FIFO entry layout and
// the ID/EX and EX/WB stage contents
// --------------------------------------------------

package vecDatapathPkg;

	localparam int laneCount   = 4;
	localparam int laneWidth   = 16;
	localparam int scalarWidth = 64;

	typedef logic signed [laneWidth-1:0] laneT;

	// Lane 0 sits in the low bits
	typedef laneT [laneCount-1:0] vecT;

	// Scalar operand on top, instruction word below
	typedef struct packed {
		logic [scalarWidth-1:0] scalar;
		isaPkg::instrT          instr;
	} fifoEntryT;

	typedef struct packed {
		logic            valid;
		isaPkg::ctrlT    ctrl;
		isaPkg::regAddrT src1;
		isaPkg::regAddrT src2;
		vecT             opA;
		vecT             opB;
		laneT            bcast;
	} idExT;

	typedef struct packed {
		logic            valid;
		logic            regWrite;
		isaPkg::regAddrT dst;
		vecT             result;
	} wbT;

endpackage

/* hw/vecDecoder.sv */
// --------------------------------------------------
// Vector instruction decoder
// Maps the opcode to a functional unit select and the
// write enable, passes saturation and destination
// --------------------------------------------------

`timescale 1ns/1ps

module vecDecoder (
	input  isaPkg::instrT instr,
	output isaPkg::ctrlT  ctrl
);
	import isaPkg::*;

	always_comb begin
		// Defaults describe a no-op
		ctrl.regWrite = 1'b0;
		ctrl.fuSel    = fuAlu;
		ctrl.subtract = 1'b0;
		ctrl.sat      = instr.sat;
		ctrl.dst      = instr.dst;

		case (instr.opcode)
			opAdd: begin
				ctrl.regWrite = 1'b1;
				ctrl.fuSel    = fuAlu;
			end
			opSub: begin
				ctrl.regWrite = 1'b1;
				ctrl.fuSel    = fuAlu;
				ctrl.subtract = 1'b1;
			end
			opMul: begin
				ctrl.regWrite = 1'b1;
				ctrl.fuSel    = fuMul;
			end
			opRelu: begin
				ctrl.regWrite = 1'b1;
				ctrl.fuSel    = fuRelu;
			end
			opBcast: begin
				ctrl.regWrite = 1'b1;
				ctrl.fuSel    = fuBcast;
			end
			// opNop and unused codes never write back
			default: begin
				ctrl.regWrite = 1'b0;
			end
		endcase
	end

endmodule

/* hw/vecRegFile.sv */
// --------------------------------------------------
// Vector register file
// 32 vectors, two asynchronous read ports and one
// write port with write-through to both reads
// --------------------------------------------------

`timescale 1ns/1ps

module vecRegFile (
	input  logic                  clk,
	input  logic                  rstN,
	input  isaPkg::regAddrT       rdAddrA,
	input  isaPkg::regAddrT       rdAddrB,
	output vecDatapathPkg::vecT   rdDataA,
	output vecDatapathPkg::vecT   rdDataB,
	input  logic                  wrEn,
	input  isaPkg::regAddrT       wrAddr,
	input  vecDatapathPkg::vecT   wrData
);
	import isaPkg::*;
	import vecDatapathPkg::*;

	localparam int regCount = 2 ** $bits(regAddrT);

	vecT regs [regCount];

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			for (int i = 0; i < regCount; i++) begin
				regs[i] <= '0;
			end
		end else if (wrEn) begin
			regs[wrAddr] <= wrData;
		end
	end

	// Write-through so ID sees the value retiring this cycle
	assign rdDataA = (wrEn && (wrAddr == rdAddrA)) ? wrData : regs[rdAddrA];
	assign rdDataB = (wrEn && (wrAddr == rdAddrB)) ? wrData : regs[rdAddrB];

endmodule

/* hw/vecExecUnit.sv */
// --------------------------------------------------
// Vector execute stage
// Forwards from EX/WB, then runs the lane-wise add,
// subtract, multiply, ReLU and broadcast units
// --------------------------------------------------

`timescale 1ns/1ps

module vecExecUnit (
	input  vecDatapathPkg::idExT idEx,
	input  vecDatapathPkg::wbT   wbStage,
	output vecDatapathPkg::wbT   result
);
	import isaPkg::*;
	import vecDatapathPkg::*;

	logic fwdHit;
	vecT  opA;
	vecT  opB;

	// One extra bit to catch signed overflow
	logic signed [laneWidth:0] sumWide [laneCount];

	vecT aluVec;
	vecT mulVec;
	vecT reluVec;
	vecT bcastVec;

	// Only a writing instruction in EX/WB can forward
	assign fwdHit = wbStage.valid && wbStage.regWrite;

	assign opA = (fwdHit && (wbStage.dst == idEx.src1)) ? wbStage.result : idEx.opA;
	assign opB = (fwdHit && (wbStage.dst == idEx.src2)) ? wbStage.result : idEx.opB;

	always_comb begin
		for (int i = 0; i < laneCount; i++) begin
			if (idEx.ctrl.subtract) begin
				sumWide[i] = $signed(opA[i]) - $signed(opB[i]);
			end else begin
				sumWide[i] = $signed(opA[i]) + $signed(opB[i]);
			end

			// Clamp when the top two bits disagree
			if (idEx.ctrl.sat && (sumWide[i][laneWidth] != sumWide[i][laneWidth-1])) begin
				aluVec[i] = sumWide[i][laneWidth] ? {1'b1, {(laneWidth-1){1'b0}}}
				                                  : {1'b0, {(laneWidth-1){1'b1}}};
			end else begin
				aluVec[i] = sumWide[i][laneWidth-1:0];
			end

			// Low half of the product is sign independent
			mulVec[i] = opA[i] * opB[i];

			reluVec[i] = opA[i][laneWidth-1] ? '0 : opA[i];

			bcastVec[i] = idEx.bcast;
		end
	end

	always_comb begin
		result.valid    = idEx.valid;
		result.regWrite = idEx.ctrl.regWrite;
		result.dst      = idEx.ctrl.dst;

		case (idEx.ctrl.fuSel)
			fuAlu:   result.result = aluVec;
			fuMul:   result.result = mulVec;
			fuRelu:  result.result = reluVec;
			fuBcast: result.result = bcastVec;
			default: result.result = aluVec;
		endcase
	end

endmodule

/* hw/vecDatapath.sv */
// --------------------------------------------------
// Pipelined vector datapath
// Pulls instructions from an external FIFO and runs
// them through IF/ID, ID/EX and EX/WB registers
// The hold input freezes all three stages
// --------------------------------------------------

`timescale 1ns/1ps

module vecDatapath (
	input  logic                      clk,
	input  logic                      rstN,
	input  logic                      hold,
	input  vecDatapathPkg::fifoEntryT fifoRdData,
	input  logic                      fifoDataValid,
	output logic                      fifoRead,
	output logic                      wbValid,
	output isaPkg::regAddrT           wbAddr,
	output vecDatapathPkg::vecT       wbData
);
	import isaPkg::*;
	import vecDatapathPkg::*;

	logic      consume;
	logic      ifIdValid;
	fifoEntryT ifIdEntry;
	ctrlT      idCtrl;
	vecT       rdDataA;
	vecT       rdDataB;
	idExT      idExD;
	idExT      idExQ;
	wbT        exWbD;
	wbT        exWbQ;

	// Fetch
	assign fifoRead = ~hold;
	assign consume  = fifoRead & fifoDataValid;

	// IF/ID takes a bubble when nothing is consumed
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			ifIdValid <= 1'b0;
		end else if (!hold) begin
			ifIdValid <= consume;
		end
	end

	always_ff @(posedge clk) begin
		if (consume) begin
			ifIdEntry <= fifoRdData;
		end
	end

	// Decode and operand read
	vecDecoder decoder (
		.instr (ifIdEntry.instr),
		.ctrl  (idCtrl)
	);

	vecRegFile regFile (
		.clk     (clk),
		.rstN    (rstN),
		.rdAddrA (ifIdEntry.instr.src1),
		.rdAddrB (ifIdEntry.instr.src2),
		.rdDataA (rdDataA),
		.rdDataB (rdDataB),
		.wrEn    (wbValid),
		.wrAddr  (wbAddr),
		.wrData  (wbData)
	);

	always_comb begin
		idExD.valid = ifIdValid;
		idExD.ctrl  = idCtrl;
		idExD.src1  = ifIdEntry.instr.src1;
		idExD.src2  = ifIdEntry.instr.src2;
		idExD.opA   = rdDataA;
		idExD.opB   = rdDataB;
		// Broadcast value is the low lane of the scalar operand
		idExD.bcast = ifIdEntry.scalar[laneWidth-1:0];
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			idExQ <= '0;
		end else if (!hold) begin
			idExQ <= idExD;
		end
	end

	// Execute
	vecExecUnit execUnit (
		.idEx    (idExQ),
		.wbStage (exWbQ),
		.result  (exWbD)
	);

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			exWbQ <= '0;
		end else if (!hold) begin
			exWbQ <= exWbD;
		end
	end

	// Write-back is suppressed while held
	assign wbValid = exWbQ.valid & exWbQ.regWrite & ~hold;
	assign wbAddr  = exWbQ.dst;
	assign wbData  = exWbQ.result;

endmodule

/* verification/vecDatapath_sva.sv */
// --------------------------------------------------
// Vector datapath port assertions
// Fetch strobe against hold, and write-back quiet
// while held, in reset and while the pipe refills
// --------------------------------------------------

`timescale 1ns/1ps

module vecDatapath_sva (
	input logic clk,
	input logic rstN,
	input logic hold,
	input logic fifoRead,
	input logic wbValid
);

	fetchFollowsHold: assert property (@(posedge clk) fifoRead == !hold)
		else $error("fifoRead is not the inverse of hold");

	noWbWhileHeld: assert property (@(posedge clk) hold |-> !wbValid)
		else $error("wbValid high while hold is high");

	noWbInReset: assert property (@(posedge clk) !rstN |-> !wbValid)
		else $error("wbValid high during reset");

	// Three stages to fill before the first write-back
	noEarlyWb: assert property (@(posedge clk)
		$rose(rstN) |-> !wbValid ##1 !wbValid ##1 !wbValid)
		else $error("wbValid high within three cycles of reset release");

endmodule

bind vecDatapath vecDatapath_sva portChecks (.*);

/* verification/vecDatapathTb.sv */
// --------------------------------------------------
// Vector datapath testbench
// Random FIFO traffic with hold pulses and valid gaps,
// checked against a sequential model of the ISA
// --------------------------------------------------

`timescale 1ns/1ps

module vecDatapathTb;
	import isaPkg::*;
	import vecDatapathPkg::*;

	localparam int numEntries    = 400;
	localparam int timeoutCycles = 4 * numEntries + 100;

	logic      clk;
	logic      rstN;
	logic      hold;
	fifoEntryT fifoRdData;
	logic      fifoDataValid;
	logic      fifoRead;
	logic      wbValid;
	regAddrT   wbAddr;
	vecT       wbData;

	vecT     modelRegs [32];
	regAddrT expAddr [$];
	vecT     expData [$];
	string   expName [$];
	int      cycleCount = 0;

	vecDatapath vecDatapath_inst (.*);

	always #20 clk = ~clk;

	// Directed head followed by random traffic on registers 0..7
	function automatic fifoEntryT makeEntry(input int idx);
		fifoEntryT   e;
		logic [4:0]  op;
		regAddrT     dst;
		regAddrT     s1;
		regAddrT     s2;
		logic        sat;
		logic [15:0] val;
		dst = 5'($urandom_range(0, 7));
		s1  = 5'($urandom_range(0, 7));
		s2  = 5'($urandom_range(0, 7));
		sat = 1'($urandom_range(0, 1));
		case ($urandom_range(0, 9))
			0: op = opNop;
			1: op = 5'd13;
			2, 3: op = opAdd;
			4: op = opSub;
			5: op = opMul;
			6: op = opRelu;
			default: op = opBcast;
		endcase
		// Fill registers early
		if (idx < 60 && $urandom_range(0, 1) == 0) op = opBcast;
		// Scalars cluster near the signed limits
		case ($urandom_range(0, 2))
			0: val = 16'h7fff - 16'($urandom_range(0, 15));
			1: val = 16'h8000 + 16'($urandom_range(0, 15));
			default: val = 16'($urandom);
		endcase
		case (idx)
			0: {op, dst, val} = {opBcast, 5'd1, 16'h1234};
			1: {op, dst, s1, s2, sat} = {opAdd, 5'd2, 5'd1, 5'd0, 1'b0};
			2: {op, dst, val} = {opBcast, 5'd3, 16'h7ff0};
			3: {op, dst, s1, s2, sat} = {opAdd, 5'd4, 5'd3, 5'd3, 1'b1};
			4: {op, dst, s1, s2, sat} = {opAdd, 5'd5, 5'd3, 5'd3, 1'b0};
			5: {op, dst, val} = {opBcast, 5'd6, 16'h8008};
			6: {op, dst, s1, s2, sat} = {opSub, 5'd7, 5'd6, 5'd3, 1'b1};
			default: ;
		endcase
		e.scalar        = {$urandom, $urandom};
		e.scalar[15:0]  = val;
		e.instr         = instrT'({3'b0, dst, s1, s2, sat, 5'b0, op, 3'b0});
		return e;
	endfunction

	// Sequential reference model run one entry at a time
	task automatic runModel(input fifoEntryT e);
		logic [4:0] op;
		laneT       la;
		laneT       lb;
		vecT        r;
		int         s;
		string      name;
		op = e.instr.opcode;
		name = "nop";
		r = '0;
		for (int i = 0; i < laneCount; i++) begin
			la = modelRegs[e.instr.src1][i];
			lb = modelRegs[e.instr.src2][i];
			case (op)
				opAdd, opSub: begin
					name = e.instr.sat ? "saturating add/sub" : "wrapping add/sub";
					s = (op == opSub) ? int'(la) - int'(lb) : int'(la) + int'(lb);
					if (e.instr.sat && s > 32767) s = 32767;
					if (e.instr.sat && s < -32768) s = -32768;
					r[i] = s[15:0];
				end
				opMul: begin
					name = "multiply";
					s = int'(la) * int'(lb);
					r[i] = s[15:0];
				end
				opRelu: begin
					name = "relu";
					r[i] = (la < 0) ? 16'sd0 : la;
				end
				opBcast: begin
					name = "broadcast";
					r[i] = e.scalar[15:0];
				end
				default: ;
			endcase
		end
		if (op inside {opAdd, opSub, opMul, opRelu, opBcast}) begin
			modelRegs[e.instr.dst] = r;
			expAddr.push_back(e.instr.dst);
			expData.push_back(r);
			expName.push_back(name);
		end
	endtask

	always @(posedge clk) begin
		int      pending;
		regAddrT addr;
		vecT     data;
		string   name;
		pending = expAddr.size();
		assert (fifoRead == !hold) else begin
			$display("Fail fetch strobe: expected fifoRead = %b, actual %b", !hold, fifoRead);
			$display("TESTBENCH FAILED");
			$fatal(1, "fifoRead does not follow hold");
		end
		if (rstN && !hold && fifoDataValid) runModel(fifoRdData);
		if (wbValid) begin
			assert (!hold) else begin
				$display("Write-back to r%0d while hold is high", wbAddr);
				$display("TESTBENCH FAILED");
				$fatal(1, "Write-back during hold");
			end
			assert (pending != 0) else begin
				$display("Write-back to r%0d with no writing instruction outstanding", wbAddr);
				$display("TESTBENCH FAILED");
				$fatal(1, "Unexpected write-back");
			end
			addr = expAddr.pop_front();
			data = expData.pop_front();
			name = expName.pop_front();
			assert (wbAddr == addr && wbData == data) else begin
				$display("Fail %s: expected r%0d = %h, actual r%0d = %h",
				         name, addr, data, wbAddr, wbData);
				$display("TESTBENCH FAILED");
				$fatal(1, "Write-back mismatch");
			end
		end
	end

	always @(posedge clk) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= timeoutCycles) begin
			$display("Run exceeded %0d cycles with %0d write-backs outstanding",
			         timeoutCycles, expAddr.size());
			$display("TESTBENCH FAILED");
			$fatal(1, "Cycle limit reached");
		end
	end

	initial begin
		int        issued;
		fifoEntryT next;
		void'($urandom(98991));
		clk           = 1'b0;
		rstN          = 1'b0;
		hold          = 1'b0;
		fifoDataValid = 1'b0;
		fifoRdData    = '0;
		for (int i = 0; i < 32; i++) modelRegs[i] = '0;
		issued = 0;
		next   = makeEntry(0);
		repeat (8) @(posedge clk);
		@(negedge clk);
		rstN = 1'b1;
		while (issued < numEntries) begin
			@(negedge clk);
			// Entry was taken at the rising edge just passed
			if (fifoDataValid && !hold) begin
				issued++;
				next = makeEntry(issued);
			end
			hold          = ($urandom_range(0, 7) == 0);
			fifoDataValid = (issued < numEntries) && ($urandom_range(0, 5) != 0);
			fifoRdData    = next;
		end
		hold = 1'b0;
		// Last entry retires three edges after its fetch
		repeat (4) @(negedge clk);
		if (expAddr.size() == 0) begin
			$display("TESTBENCH PASSED");
			$finish;
		end else begin
			$display("TESTBENCH FAILED");
			$fatal(1, "Write-backs still outstanding at the end of the run");
		end
	end

endmodule

/* vecDatapath.f */
hw/isaPkg.sv
hw/vecDatapathPkg.sv
hw/vecDecoder.sv
hw/vecRegFile.sv
hw/vecExecUnit.sv
hw/vecDatapath.sv
verification/vecDatapath_sva.sv
verification/vecDatapathTb.sv

/* Makefile */
# Verilator flow for the vector datapath
# Override any variable on the command line, e.g. make sim BUILD_DIR=build

VERILATOR ?= verilator
TOP       ?= vecDatapathTb
FILELIST  ?= vecDatapath.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing --assert
SIM_BIN   ?= $(BUILD_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

# The simulator exits non-zero on $fatal, so make fails with it
sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(SIM_BIN)

clean:
	rm -rf $(BUILD_DIR)
